/* Bender.yml */
package:
  name: gauss_elim

sources:
  - src/gauss_pkg.sv
  - src/matrix_ram.sv
  - src/elim_step.sv
  - src/elim_phase.sv
  - src/gauss_top.sv
  - target: test
    files:
      - testbench/tb_gauss.sv

/* src/elim_phase.sv */
`timescale 1ns/1ns

module elim_phase (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,        // One-cycle run request
  input  gauss_pkg::row_idx_t start_col,    // First pivot column
  input  logic                step_done,
  input  logic                step_fail,
  output logic                busy,         // Engine owns the memory
  output logic                step_start,
  output gauss_pkg::row_idx_t pivot_col,
  output logic                done,         // One-cycle pulse on success
  output logic                fail          // Sticky until the cycle after start
);

  gauss_pkg::col_cnt_t col_cnt;     // Current pivot column
  gauss_pkg::col_cnt_t col_next;    // Column for the coming cycle
  logic                running;     // Run in progress
  logic                last_step;   // Current column is the last one
  logic                fail_flag;   // Failure seen in this run
  logic                step_end;    // Step finished inside a run

  assign step_end = running && step_done;

  // Load on start, advance after each good step
  always_comb begin
    if (start) begin
      col_next = {1'b0, start_col};
    end else if (step_end && !last_step) begin
      col_next = col_cnt + 1'b1;
    end else begin
      col_next = col_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running    <= 1'b0;
      col_cnt    <= '0;
      last_step  <= 1'b0;
      step_start <= 1'b0;
      done       <= 1'b0;
      fail_flag  <= 1'b0;
    end else begin
      // Ends after the last step or at once on a failing step
      running    <= start || (running && !(step_done && (last_step || step_fail)));
      col_cnt    <= col_next;
      last_step  <= (col_next == gauss_pkg::col_cnt_t'(gauss_pkg::ROWS - 1));
      step_start <= start || (step_end && !last_step && !step_fail);
      done       <= step_end && last_step && !step_fail;
      if (start) begin
        fail_flag <= 1'b0;                 // New run, forget old failure
      end else if (step_end && step_fail) begin
        fail_flag <= 1'b1;                 // Rises where done would have
      end
    end
  end

  assign busy      = running;
  assign pivot_col = gauss_pkg::row_idx_t'(col_cnt);
  assign fail      = fail_flag;

endmodule

/* src/elim_step.sv */
`timescale 1ns/1ns

module elim_step (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                step_start,   // One-cycle kick from phase controller
  input  gauss_pkg::row_idx_t pivot_col,    // Held stable for the whole step
  input  gauss_pkg::row_t     rd_data,      // Row read one cycle earlier
  output gauss_pkg::row_rd_t  eng_rd,
  output gauss_pkg::row_wr_t  eng_wr,
  output logic                step_done,    // One-cycle end of step
  output logic                step_fail     // No pivot found, valid with step_done
);

  // SEARCH walks rows from the diagonal downward
  // SWEEP walks all rows and clears the pivot column
  typedef enum logic [1:0] {
    IDLE,
    SEARCH,
    SWEEP
  } state_t;

  state_t               state;
  gauss_pkg::col_cnt_t  rd_ptr;     // Next row to read, ROWS means exhausted
  logic                 rd_vld;     // rd_data carries a row this cycle
  gauss_pkg::row_idx_t  vld_addr;   // Address of the row on rd_data
  gauss_pkg::row_t      diag_row;   // Diagonal row as first read in SEARCH
  gauss_pkg::row_t      piv_row;    // Pivot row after repair, used in SWEEP
  logic                 hit;        // Pivot bit set in returned row
  logic                 is_diag;    // Returned row is the diagonal row
  logic                 last_row;   // Returned row is the bottom row
  logic                 rd_more;    // Rows left to read in this pass
  logic                 add_wr;     // Diagonal repair write
  logic                 sweep_wr;   // Elimination write-back

  // Column c lives at bit COLS-1-c
  assign hit      = rd_data[gauss_pkg::COLS - 1 - pivot_col];
  assign is_diag  = (vld_addr == pivot_col);
  assign last_row = (vld_addr == gauss_pkg::row_idx_t'(gauss_pkg::ROWS - 1));
  assign rd_more  = (state != IDLE) &&
                    (rd_ptr < gauss_pkg::col_cnt_t'(gauss_pkg::ROWS));

  // Pivot found below the diagonal, so the diagonal bit was zero
  assign add_wr   = (state == SEARCH) && rd_vld && hit && !is_diag;
  // Every non-diagonal row with the pivot bit gets the pivot row added
  assign sweep_wr = (state == SWEEP) && rd_vld && hit && !is_diag;

  // Memory requests
  // Next read overlaps the write-back of the current row
  always_comb begin
    eng_rd.en   = rd_more;
    eng_rd.addr = gauss_pkg::row_idx_t'(rd_ptr);
    eng_wr.en   = add_wr || sweep_wr;
    eng_wr.addr = add_wr ? pivot_col : vld_addr;     // Repair targets the diagonal
    if (add_wr) begin
      eng_wr.data = rd_data ^ diag_row;              // GF(2) row addition
    end else begin
      eng_wr.data = rd_data ^ piv_row;               // Clear pivot column
    end
  end

  // Control FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      rd_ptr    <= '0;
      rd_vld    <= 1'b0;
      step_done <= 1'b0;
      step_fail <= 1'b0;
    end else begin
      rd_vld    <= eng_rd.en;                        // Data follows one cycle later
      step_done <= 1'b0;
      step_fail <= 1'b0;
      case (state)
        IDLE: begin
          if (step_start) begin
            state  <= SEARCH;
            rd_ptr <= {1'b0, pivot_col};             // Rows above are finished
          end
        end
        SEARCH: begin
          if (eng_rd.en) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          if (rd_vld && hit) begin
            state  <= SWEEP;
            rd_ptr <= '0;                            // Sweep covers every row
            rd_vld <= 1'b0;                          // Drop the read in flight
          end else if (rd_vld && last_row) begin
            state     <= IDLE;                       // Column has no pivot
            step_done <= 1'b1;
            step_fail <= 1'b1;
          end
        end
        SWEEP: begin
          if (eng_rd.en) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          if (rd_vld && last_row) begin
            state     <= IDLE;                       // Bottom row written back
            step_done <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Row datapath
  always_ff @(posedge clk) begin
    vld_addr <= gauss_pkg::row_idx_t'(rd_ptr);       // Tag for the returning row
    if (state == SEARCH && rd_vld && is_diag) begin
      diag_row <= rd_data;                           // First row of every search
    end
    if (state == SEARCH && rd_vld && hit) begin
      if (is_diag) begin
        piv_row <= rd_data;                          // Diagonal already usable
      end else begin
        piv_row <= rd_data ^ diag_row;               // Same value as the repair write
      end
    end
  end

endmodule

/* src/gauss_pkg.sv */
package gauss_pkg;

  // Matrix geometry
  localparam int ROWS = 8;                // Matrix rows, one pivot per row
  localparam int COLS = 16;               // Row width in bits
  localparam int ROW_AW = $clog2(ROWS);   // Row address width

  // Row address, also used as pivot column index
  typedef logic [ROW_AW-1:0] row_idx_t;

  // Column counter, one extra bit so it can hold ROWS
  typedef logic [ROW_AW:0] col_cnt_t;

  // Column c of the matrix sits at bit COLS-1-c
  // Left block is columns 0..7, i.e. the upper byte
  typedef logic [COLS-1:0] row_t;

  // Row write access
  typedef struct packed {
    logic     en;     // Single-cycle write strobe
    row_idx_t addr;   // Row to write
    row_t     data;   // New row contents
  } row_wr_t;

  // Row read access
  // Data is returned one cycle after en
  typedef struct packed {
    logic     en;     // Single-cycle read strobe
    row_idx_t addr;   // Row to read
  } row_rd_t;

endpackage

/* src/gauss_top.sv */
`timescale 1ns/1ns

module gauss_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,       // One-cycle run request
  input  gauss_pkg::row_idx_t start_col,   // First pivot column of the run
  output logic                done,        // Run completed, matrix systematic
  output logic                fail,        // Run stopped, no pivot in a column
  input  gauss_pkg::row_rd_t  host_rd,     // Host read, only while idle
  output gauss_pkg::row_t     rd_data,     // Read row, one cycle after strobe
  input  gauss_pkg::row_wr_t  host_wr      // Host write, only while idle
);

  logic                busy;         // Run active, engine owns memory
  logic                step_start;   // Phase to step kick
  logic                step_done;    // Step to phase completion
  logic                step_fail;    // Step found no pivot
  gauss_pkg::row_idx_t pivot_col;    // Column under elimination
  gauss_pkg::row_rd_t  eng_rd;       // Engine read request
  gauss_pkg::row_wr_t  eng_wr;       // Engine write request

  // Row storage and host port
  matrix_ram u_matrix_ram (
    .clk     (clk),
    .busy    (busy),
    .host_rd (host_rd),
    .host_wr (host_wr),
    .eng_rd  (eng_rd),
    .eng_wr  (eng_wr),
    .rd_data (rd_data)
  );

  // Column sequencing
  elim_phase u_elim_phase (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .start_col  (start_col),
    .step_done  (step_done),
    .step_fail  (step_fail),
    .busy       (busy),
    .step_start (step_start),
    .pivot_col  (pivot_col),
    .done       (done),
    .fail       (fail)
  );

  // One elimination step per column
  // Shares rd_data with the host side
  elim_step u_elim_step (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_start (step_start),
    .pivot_col  (pivot_col),
    .rd_data    (rd_data),
    .eng_rd     (eng_rd),
    .eng_wr     (eng_wr),
    .step_done  (step_done),
    .step_fail  (step_fail)
  );

endmodule

/* src/matrix_ram.sv */
`timescale 1ns/1ns

module matrix_ram (
  input  logic               clk,
  input  logic               busy,      // Engine owns the memory
  input  gauss_pkg::row_rd_t host_rd,
  input  gauss_pkg::row_wr_t host_wr,
  input  gauss_pkg::row_rd_t eng_rd,
  input  gauss_pkg::row_wr_t eng_wr,
  output gauss_pkg::row_t    rd_data    // Shared by host and engine
);

  gauss_pkg::row_t    mem [gauss_pkg::ROWS];   // One whole row per word
  gauss_pkg::row_rd_t rd_sel;                  // Read port in use
  gauss_pkg::row_wr_t wr_sel;                  // Write port in use

  // Engine wins whenever a run is active
  // Host and engine never access in the same cycle
  always_comb begin
    if (busy) begin
      rd_sel = eng_rd;
      wr_sel = eng_wr;
    end else begin
      rd_sel = host_rd;
      wr_sel = host_wr;
    end
  end

  // Write array, no reset on contents
  always_ff @(posedge clk) begin
    if (wr_sel.en) begin
      mem[wr_sel.addr] <= wr_sel.data;   // Full row replace
    end
  end

  // Registered read, old data on same-address write
  // Output holds between strobes
  always_ff @(posedge clk) begin
    if (rd_sel.en) begin
      rd_data <= mem[rd_sel.addr];       // Valid one cycle after strobe
    end
  end

endmodule

/* tb.f */
src/gauss_pkg.sv
src/matrix_ram.sv
src/elim_step.sv
src/elim_phase.sv
src/gauss_top.sv
testbench/tb_gauss.sv

/* testbench/gauss_trace.txt */
# W row value | S start_col | R row expected | F expected_fail
# Hex values, column 0 of the matrix is bit 15 of a row
W 0 803c
W 1 40a5
W 2 205a
W 3 100f
W 4 08f0
W 5 0499
W 6 0266
W 7 01c3
S 0
F 0
R 0 803c
R 1 40a5
R 2 205a
R 3 100f
R 4 08f0
R 5 0499
R 6 0266
R 7 01c3
W 0 d069
W 1 b4b9
W 2 287d
W 3 7d86
W 4 f298
W 5 07b4
W 6 1a89
W 7 6fbb
S 0
F 0
R 0 801e
R 1 4072
R 2 20c9
R 3 1005
R 4 08b4
R 5 046b
R 6 0238
R 7 01e7
W 0 24c3
W 1 80aa
W 2 6066
W 3 11b2
W 4 0281
W 5 0cff
W 6 017e
W 7 18c3
S 0
F 0
R 0 80aa
R 1 4055
R 2 2033
R 3 10cc
R 4 080f
R 5 04f0
R 6 0281
R 7 017e
W 0 8001
W 1 4002
W 2 2004
W 3 1008
W 4 0810
W 5 0420
W 6 0240
W 7 0280
S 0
F 1
W 0 81c0
W 1 4011
W 2 2022
W 3 1044
W 4 0888
W 5 0403
W 6 020c
W 7 2112
S 0
F 0
R 0 80f0
R 1 4011
R 2 2022
R 3 1044
R 4 0888
R 5 0403
R 6 020c
R 7 0130
W 0 847d
W 1 4028
W 2 29e0
W 3 1235
W 4 0617
W 5 0c31
W 6 0273
W 7 09d7
S 4
F 0
R 0 8019
R 1 4028
R 2 2037
R 3 1046
R 4 0855
R 5 0464
R 6 0273
R 7 0182

/* testbench/tb_gauss.sv */
`timescale 1ns/1ns

module tb_gauss;

  localparam int STEP_MAX = 2 * gauss_pkg::ROWS + 4;   // Worst case cycles per step
  localparam int RUN_MAX  = 8 * STEP_MAX + 2;          // Worst case cycles per run

  logic                clk;
  logic                rst_n;
  logic                start;
  gauss_pkg::row_idx_t start_col;
  logic                done;
  logic                fail;
  gauss_pkg::row_rd_t  host_rd;
  gauss_pkg::row_t     rd_data;
  gauss_pkg::row_wr_t  host_wr;

  byte         cmd_q[$];       // Command letters from the trace
  int          arg_a_q[$];     // Row, column or flag
  int          arg_b_q[$];     // Row value
  int          limit_cycles;   // Zero until the trace is loaded
  int          cycles;
  int          errors;
  int          test_errs;      // Errors inside the open test
  int          test_num;
  int          tests_failed;
  int          n_starts;
  int          i;
  logic        test_open;
  logic        run_done;       // done seen at the end of the last run
  logic        run_fail;       // Outcome of the last run
  int unsigned seed_val;

  gauss_top u_gauss_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .start_col (start_col),
    .done      (done),
    .fail      (fail),
    .host_rd   (host_rd),
    .rd_data   (rd_data),
    .host_wr   (host_wr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                            // 40 ns period
  end

  // Watchdog over the whole trace
  initial begin
    wait (limit_cycles > 0);
    cycles = 0;
    while (cycles < limit_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: trace not finished after %0d cycles", cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp_val);
    if (got !== exp_val) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp_val);
      errors++;
      test_errs++;
    end
  endtask

  task automatic load_trace();
    int  fd;
    int  n;
    int  ch;
    byte cmd;
    int  a;
    int  b;
    fd = $fopen("testbench/gauss_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/gauss_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", cmd);
      if (n != 1) begin
        break;
      end
      b = 0;
      if (cmd == "#") begin
        ch = $fgetc(fd);                               // Skip comment line
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        if (cmd == "S" || cmd == "F") begin
          n = $fscanf(fd, "%h", a);
        end else begin
          n = $fscanf(fd, "%h %h", a, b);
        end
        cmd_q.push_back(cmd);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  task automatic write_row(input int row, input int value);
    @(posedge clk);
    host_wr.en   <= 1'b1;
    host_wr.addr <= gauss_pkg::row_idx_t'(row);
    host_wr.data <= gauss_pkg::row_t'(value);
    @(posedge clk);
    host_wr.en   <= 1'b0;                              // Row taken on this edge
  endtask

  task automatic read_row(input int row, input int exp_val);
    @(posedge clk);
    host_rd.en   <= 1'b1;
    host_rd.addr <= gauss_pkg::row_idx_t'(row);
    @(posedge clk);
    host_rd.en   <= 1'b0;
    @(negedge clk);                                    // Data one cycle after strobe
    check_value($sformatf("rd_data[row %0d]", row), rd_data, gauss_pkg::row_t'(exp_val));
  endtask

  task automatic run_from(input int col);
    int   waited;
    logic seen;
    @(posedge clk);
    start     <= 1'b1;
    start_col <= gauss_pkg::row_idx_t'(col);
    @(posedge clk);
    start     <= 1'b0;                                 // Sticky fail cleared here
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < RUN_MAX) begin
      @(negedge clk);
      waited++;
      seen = done || fail;
    end
    run_done = done;
    run_fail = fail;
    if (!seen) begin
      $display("Run from column %0d gave neither done nor fail in %0d cycles", col, RUN_MAX);
      errors++;
      test_errs++;
    end else if (done && fail) begin
      $display("Run from column %0d raised done and fail together", col);
      errors++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (test_open) begin
      if (test_errs == 0) begin
        $display("test %0d passed", test_num);
      end else begin
        $display("test %0d failed with %0d errors", test_num, test_errs);
        tests_failed++;
      end
      test_open = 1'b0;
    end
  endtask

  initial begin
    seed_val  = $urandom(32'h4ac9e4d3);                // Fixed run seed
    rst_n     = 1'b0;
    start     = 1'b0;
    start_col = '0;
    host_rd   = '0;
    host_wr   = '0;
    errors    = 0;
    test_errs = 0;
    test_num  = 0;
    tests_failed = 0;
    test_open = 1'b0;
    run_done  = 1'b0;
    run_fail  = 1'b0;
    load_trace();
    n_starts = 0;
    for (i = 0; i < cmd_q.size(); i++) begin
      if (cmd_q[i] == "S") begin
        n_starts++;
      end
    end
    limit_cycles = n_starts * 8 * STEP_MAX + 50 * cmd_q.size();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "W": begin
          close_test();                                // New matrix ends the last test
          write_row(arg_a_q[i], arg_b_q[i]);
        end
        "S": begin
          close_test();
          test_num++;
          test_errs = 0;
          test_open = 1'b1;
          run_from(arg_a_q[i]);
        end
        "R": read_row(arg_a_q[i], arg_b_q[i]);
        "F": begin
          check_value("done", 16'(run_done), 16'(arg_a_q[i] == 0));
          check_value("fail", 16'(run_fail), 16'(arg_a_q[i]));
          @(negedge clk);
          check_value("done after pulse", 16'(done), 16'(0));   // One-cycle pulse
          check_value("fail held", 16'(fail), 16'(arg_a_q[i]));  // Sticky until next start
        end
        default: begin
          $display("Unknown trace command %c at entry %0d", cmd_q[i], i);
          errors++;
        end
      endcase
    end
    close_test();
    $display("tests run %0d, tests failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0 && test_num > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
